// ==== hw/vgaPkg.sv ====
`default_nettype none

package vgaPkg;

	// Frame memory word address is {row, column, 2'b00}
	localparam int addrBits = 13;
	localparam int rowBits = 7;
	localparam int colBits = 4;

	localparam int hCountBits = 11;
	localparam int vCountBits = 10;
	localparam int stretchBits = 4;

	// Five packed pixels per word, each {blue, green, red}
	localparam int subPixels = 5;
	localparam int subBits = $clog2(subPixels);
	localparam logic [subBits-1:0] lastSub = subBits'(subPixels - 1);
	localparam int pixelBits = 6;
	localparam int colourBits = 2;

	localparam logic [11:0] regConfig = 12'h000;
	localparam logic [11:0] regHVisible = 12'h010;
	localparam logic [11:0] regHFrontPorch = 12'h014;
	localparam logic [11:0] regHSync = 12'h018;
	localparam logic [11:0] regHWhole = 12'h01C;
	localparam logic [11:0] regVVisible = 12'h020;
	localparam logic [11:0] regVFrontPorch = 12'h024;
	localparam logic [11:0] regVSync = 12'h028;
	localparam logic [11:0] regVWhole = 12'h02C;
	localparam logic [11:0] regStatus = 12'h030;

	// Configuration word, bits 9:8 are unused and read back as zero
	localparam int configBits = 11;
	localparam int cfgHSizeLsb = 0;
	localparam int cfgVSizeLsb = 4;
	localparam int cfgEnableBit = 10;
	localparam logic [configBits-1:0] configWriteMask = 11'h4FF;
	localparam logic [configBits-1:0] configDefault = 11'h0AA;

	// 800 x 600 at 60 Hz
	localparam logic [hCountBits-1:0] hVisibleDefault = 11'd799;
	localparam logic [hCountBits-1:0] hFrontPorchDefault = 11'd839;
	localparam logic [hCountBits-1:0] hSyncDefault = 11'd967;
	localparam logic [hCountBits-1:0] hWholeDefault = 11'd1055;
	localparam logic [vCountBits-1:0] vVisibleDefault = 10'd599;
	localparam logic [vCountBits-1:0] vFrontPorchDefault = 10'd600;
	localparam logic [vCountBits-1:0] vSyncDefault = 10'd604;
	localparam logic [vCountBits-1:0] vWholeDefault = 10'd627;

	localparam int statEnable = 0;
	localparam int statHsync = 1;
	localparam int statVsync = 2;
	localparam int statHVisible = 3;
	localparam int statVVisible = 4;

	localparam logic [31:0] unmappedRead = '1;

endpackage

`default_nettype wire

// ==== hw/vgaRegisterBank.sv ====
`default_nettype none

module vgaRegisterBank
	import vgaPkg::*;
(
	input wire vga_clk,
	input wire rstN,
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire [11:0] wbAdr,
	input wire [3:0] wbSel,
	input wire [31:0] wbDatW,
	input wire syncH,
	input wire syncV,
	input wire visibleH,
	input wire visibleV,
	output logic [31:0] wbDatR,
	output logic wbAck,
	output logic [hCountBits-1:0] hVisible,
	output logic [hCountBits-1:0] hFrontPorch,
	output logic [hCountBits-1:0] hSync,
	output logic [hCountBits-1:0] hWhole,
	output logic [vCountBits-1:0] vVisible,
	output logic [vCountBits-1:0] vFrontPorch,
	output logic [vCountBits-1:0] vSync,
	output logic [vCountBits-1:0] vWhole,
	output logic [stretchBits-1:0] hPixelSize,
	output logic [stretchBits-1:0] vPixelSize,
	output logic outputEnable
);

	logic [configBits-1:0] configReg;
	logic [31:0] statusWord;
	logic [31:0] readWord;
	logic access;
	logic writeStrobe;

	// Byte lanes not selected keep their old contents
	function automatic logic [31:0] mergeBytes(input logic [31:0] oldValue);
		logic [31:0] merged;
		merged = oldValue;
		for (int i = 0; i < 4; i++) begin
			if (wbSel[i]) begin
				merged[8*i +: 8] = wbDatW[8*i +: 8];
			end
		end
		return merged;
	endfunction

	assign access = wbCyc && wbStb && !wbAck;
	assign writeStrobe = access && wbWe;

	assign hPixelSize = configReg[cfgHSizeLsb +: stretchBits];
	assign vPixelSize = configReg[cfgVSizeLsb +: stretchBits];
	assign outputEnable = configReg[cfgEnableBit];

	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			configReg <= configDefault;
			hVisible <= hVisibleDefault;
			hFrontPorch <= hFrontPorchDefault;
			hSync <= hSyncDefault;
			hWhole <= hWholeDefault;
			vVisible <= vVisibleDefault;
			vFrontPorch <= vFrontPorchDefault;
			vSync <= vSyncDefault;
			vWhole <= vWholeDefault;
		end else if (writeStrobe) begin
			case (wbAdr)
				regConfig: configReg <= configBits'(mergeBytes(32'(configReg))) & configWriteMask;
				regHVisible: hVisible <= hCountBits'(mergeBytes(32'(hVisible)));
				regHFrontPorch: hFrontPorch <= hCountBits'(mergeBytes(32'(hFrontPorch)));
				regHSync: hSync <= hCountBits'(mergeBytes(32'(hSync)));
				regHWhole: hWhole <= hCountBits'(mergeBytes(32'(hWhole)));
				regVVisible: vVisible <= vCountBits'(mergeBytes(32'(vVisible)));
				regVFrontPorch: vFrontPorch <= vCountBits'(mergeBytes(32'(vFrontPorch)));
				regVSync: vSync <= vCountBits'(mergeBytes(32'(vSync)));
				regVWhole: vWhole <= vCountBits'(mergeBytes(32'(vWhole)));
				default: ;
			endcase
		end
	end

	// Sync outputs are active low, status reports them as active high
	always_comb begin
		statusWord = '0;
		statusWord[statEnable] = outputEnable;
		statusWord[statHsync] = !syncH;
		statusWord[statVsync] = !syncV;
		statusWord[statHVisible] = visibleH;
		statusWord[statVVisible] = visibleV;
	end

	always_comb begin
		case (wbAdr)
			regConfig: readWord = 32'(configReg);
			regHVisible: readWord = 32'(hVisible);
			regHFrontPorch: readWord = 32'(hFrontPorch);
			regHSync: readWord = 32'(hSync);
			regHWhole: readWord = 32'(hWhole);
			regVVisible: readWord = 32'(vVisible);
			regVFrontPorch: readWord = 32'(vFrontPorch);
			regVSync: readWord = 32'(vSync);
			regVWhole: readWord = 32'(vWhole);
			regStatus: readWord = statusWord;
			default: readWord = unmappedRead;
		endcase
	end

	// Every access is answered in one cycle
	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= access;
		end
	end

	always_ff @(posedge vga_clk) begin
		if (access && !wbWe) begin
			wbDatR <= readWord;
		end
	end

endmodule

`default_nettype wire

// ==== hw/vgaTimingGenerator.sv ====
`default_nettype none

module vgaTimingGenerator
	import vgaPkg::*;
(
	input wire vga_clk,
	input wire rstN,
	input wire outputEnable,
	input wire [hCountBits-1:0] hVisible,
	input wire [hCountBits-1:0] hFrontPorch,
	input wire [hCountBits-1:0] hSync,
	input wire [hCountBits-1:0] hWhole,
	input wire [vCountBits-1:0] vVisible,
	input wire [vCountBits-1:0] vFrontPorch,
	input wire [vCountBits-1:0] vSync,
	input wire [vCountBits-1:0] vWhole,
	output logic lineEnd,
	output logic hVisibleArea,
	output logic vVisibleArea,
	output logic hSyncRaw,
	output logic vSyncRaw
);

	logic [hCountBits-1:0] hCount;
	logic [vCountBits-1:0] vCount;
	logic frameEnd;

	assign lineEnd = hCount == hWhole;
	assign frameEnd = vCount == vWhole;

	always_ff @(posedge vga_clk) begin
		if (!rstN || !outputEnable) begin
			hCount <= '0;
			hVisibleArea <= 1'b1;
			hSyncRaw <= 1'b1;
		end else begin
			hCount <= lineEnd ? '0 : hCount + 1'b1;
			if (hCount == hVisible) begin
				hVisibleArea <= 1'b0;
			end else if (lineEnd) begin
				hVisibleArea <= 1'b1;
			end
			// Front porch end wins if both compares hit together
			if (hCount == hFrontPorch) begin
				hSyncRaw <= 1'b0;
			end else if (hCount == hSync) begin
				hSyncRaw <= 1'b1;
			end
		end
	end

	// Vertical state only steps on the last cycle of a line
	always_ff @(posedge vga_clk) begin
		if (!rstN || !outputEnable) begin
			vCount <= '0;
			vVisibleArea <= 1'b1;
			vSyncRaw <= 1'b1;
		end else if (lineEnd) begin
			vCount <= frameEnd ? '0 : vCount + 1'b1;
			if (vCount == vVisible) begin
				vVisibleArea <= 1'b0;
			end else if (frameEnd) begin
				vVisibleArea <= 1'b1;
			end
			if (vCount == vFrontPorch) begin
				vSyncRaw <= 1'b0;
			end else if (vCount == vSync) begin
				vSyncRaw <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/vgaPixelFetch.sv ====
`default_nettype none

module vgaPixelFetch
	import vgaPkg::*;
(
	input wire vga_clk,
	input wire rstN,
	input wire outputEnable,
	input wire lineEnd,
	input wire hVisibleArea,
	input wire vVisibleArea,
	input wire hSyncRaw,
	input wire vSyncRaw,
	input wire [stretchBits-1:0] hPixelSize,
	input wire [stretchBits-1:0] vPixelSize,
	input wire [31:0] pixelData,
	output logic fetchData,
	output logic [addrBits-1:0] pixelAddress,
	output logic [colourBits-1:0] vgaR,
	output logic [colourBits-1:0] vgaG,
	output logic [colourBits-1:0] vgaB,
	output logic vgaHsync,
	output logic vgaVsync
);

	logic [stretchBits-1:0] hStretch, hStretchNext;
	logic [stretchBits-1:0] vStretch, vStretchNext;
	logic [subBits-1:0] subPixel, subNext;
	logic [hCountBits-1:0] column, columnNext;
	logic [vCountBits-1:0] row, rowNext;
	logic active;
	logic fetchPending;
	logic [31:0] wordLatch;
	logic [31:0] wordSource;
	logic [pixelBits-1:0] pixel;
	logic [subBits-1:0] subA;
	logic onScreenA;
	logic firstA;
	logic hSyncA;
	logic vSyncA;

	always_comb begin
		hStretchNext = hStretch;
		vStretchNext = vStretch;
		subNext = subPixel;
		columnNext = column;
		rowNext = row;
		if (!outputEnable || !vVisibleArea) begin
			hStretchNext = '0;
			vStretchNext = '0;
			subNext = '0;
			columnNext = '0;
			rowNext = '0;
		end else begin
			if (!hVisibleArea) begin
				hStretchNext = '0;
				subNext = '0;
				columnNext = '0;
			end else if (hStretch == hPixelSize) begin
				hStretchNext = '0;
				subNext = (subPixel == lastSub) ? '0 : subPixel + 1'b1;
				if (subPixel == lastSub) begin
					columnNext = column + 1'b1;
				end
			end else begin
				hStretchNext = hStretch + 1'b1;
			end
			if (lineEnd) begin
				vStretchNext = (vStretch == vPixelSize) ? '0 : vStretch + 1'b1;
				if (vStretch == vPixelSize) begin
					rowNext = row + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge vga_clk) begin
		if (!rstN) begin
			hStretch <= '0;
			vStretch <= '0;
			subPixel <= '0;
			column <= '0;
			row <= '0;
		end else begin
			hStretch <= hStretchNext;
			vStretch <= vStretchNext;
			subPixel <= subNext;
			column <= columnNext;
			row <= rowNext;
		end
	end

	// Address follows the next counter state so the word arrives with that state.
	// The first enabled cycle also fetches, since nothing was loaded before it
	assign pixelAddress = {rowNext[rowBits-1:0], columnNext[colBits-1:0], 2'b00};
	assign fetchData = outputEnable && (!active || rowNext != row || columnNext != column);

	// Stage A, state of the current cycle
	always_ff @(posedge vga_clk) begin
		if (!rstN || !outputEnable) begin
			active <= 1'b0;
			fetchPending <= 1'b0;
			subA <= '0;
			onScreenA <= 1'b0;
			firstA <= 1'b0;
			hSyncA <= 1'b1;
			vSyncA <= 1'b1;
		end else begin
			active <= 1'b1;
			fetchPending <= fetchData;
			subA <= subPixel;
			onScreenA <= hVisibleArea && vVisibleArea;
			firstA <= !active;
			hSyncA <= hSyncRaw;
			vSyncA <= vSyncRaw;
		end
	end

	always_ff @(posedge vga_clk) begin
		if (fetchPending) begin
			wordLatch <= pixelData;
		end
	end

	// First state after enable takes its word straight from memory
	assign wordSource = firstA ? pixelData : wordLatch;
	assign pixel = wordSource[subA * pixelBits +: pixelBits];

	// Stage B drives the pins
	always_ff @(posedge vga_clk) begin
		if (!rstN || !outputEnable) begin
			vgaR <= '0;
			vgaG <= '0;
			vgaB <= '0;
			vgaHsync <= 1'b1;
			vgaVsync <= 1'b1;
		end else begin
			vgaR <= onScreenA ? pixel[0 +: colourBits] : '0;
			vgaG <= onScreenA ? pixel[colourBits +: colourBits] : '0;
			vgaB <= onScreenA ? pixel[2*colourBits +: colourBits] : '0;
			vgaHsync <= hSyncA;
			vgaVsync <= vSyncA;
		end
	end

endmodule

`default_nettype wire

// ==== hw/vgaController.sv ====
`default_nettype none

module vgaController
	import vgaPkg::*;
(
	input wire vga_clk,
	input wire rstN,
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire [11:0] wbAdr,
	input wire [3:0] wbSel,
	input wire [31:0] wbDatW,
	output wire [31:0] wbDatR,
	output wire wbAck,
	output wire fetchData,
	output wire [addrBits-1:0] pixelAddress,
	input wire [31:0] pixelData,
	output wire [colourBits-1:0] vgaR,
	output wire [colourBits-1:0] vgaG,
	output wire [colourBits-1:0] vgaB,
	output wire vgaHsync,
	output wire vgaVsync
);

	wire [hCountBits-1:0] hVisible;
	wire [hCountBits-1:0] hFrontPorch;
	wire [hCountBits-1:0] hSync;
	wire [hCountBits-1:0] hWhole;
	wire [vCountBits-1:0] vVisible;
	wire [vCountBits-1:0] vFrontPorch;
	wire [vCountBits-1:0] vSync;
	wire [vCountBits-1:0] vWhole;
	wire [stretchBits-1:0] hPixelSize;
	wire [stretchBits-1:0] vPixelSize;
	wire outputEnable;
	wire lineEnd;
	wire hVisibleArea;
	wire vVisibleArea;
	wire hSyncRaw;
	wire vSyncRaw;

	// Status reports the pin-aligned syncs
	vgaRegisterBank registerBank (
		.syncH(vgaHsync),
		.syncV(vgaVsync),
		.visibleH(hVisibleArea),
		.visibleV(vVisibleArea),
		.*
	);

	vgaTimingGenerator timingGenerator (.*);

	vgaPixelFetch pixelFetch (.*);

endmodule

`default_nettype wire

// ==== test/vgaControllerTb.sv ====
`default_nettype none

module vgaControllerTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 20;
	localparam int numRuns = 4;
	localparam int maxLineCycles = 40;
	localparam int maxFrameLines = 20;
	localparam int marginCycles = 4000;
	localparam logic [11:0] configAdr = 12'h000;
	localparam logic [11:0] statusAdr = 12'h030;

	logic vga_clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [11:0] wbAdr;
	logic [3:0] wbSel;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic wbAck;
	logic fetchData;
	logic [12:0] pixelAddress;
	logic [31:0] pixelData;
	logic [1:0] vgaR;
	logic [1:0] vgaG;
	logic [1:0] vgaB;
	logic vgaHsync;
	logic vgaVsync;

	logic [31:0] lcgState = 32'h790c1ade;
	logic [31:0] frameMem [8192];
	logic fetchSeen = 1'b0;
	logic [12:0] fetchAddr;

	// Mapped registers in address order starting with the configuration word
	logic [11:0] regOffset [9] = '{12'h000, 12'h010, 12'h014, 12'h018, 12'h01C,
		12'h020, 12'h024, 12'h028, 12'h02C};
	logic [31:0] regDefault [9] = '{32'h0AA, 799, 839, 967, 1055, 599, 600, 604, 627};
	logic [31:0] regMask [9] = '{32'h4FF, 32'h7FF, 32'h7FF, 32'h7FF, 32'h7FF,
		32'h3FF, 32'h3FF, 32'h3FF, 32'h3FF};
	logic [11:0] unmappedOffset [4] = '{12'h004, 12'h011, 12'h034, 12'hFFC};

	// Reference model state and the programmed timing of the current run
	int tHVis, tHFp, tHSync, tHWhole, tVVis, tVFp, tVSync, tVWhole, tHps, tVps;
	int mHc, mVc, mHSt, mVSt, mSub, mCol, mRow;
	logic mHVis, mVVis, mHs, mVs;
	logic lastFetchValid;
	logic [12:0] lastFetchAddr;
	// Packed as {vsync, hsync, blue, green, red}
	logic [7:0] expQ [$];

	vgaController dut0 (.*);

	initial begin
		vga_clk = 1'b0;
		forever #(clkPeriod / 2) vga_clk = ~vga_clk;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState ^ (lcgState >> 15);
	endfunction

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			stopWithFailure($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
		end
	endtask

	// Frame memory answers on the cycle after a fetch request
	always @(negedge vga_clk) begin
		fetchSeen = fetchData;
		fetchAddr = pixelAddress;
	end

	always @(posedge vga_clk) begin
		if (fetchSeen) begin
			pixelData <= frameMem[fetchAddr];
		end
	end

	initial begin
		#((numRuns * 2 * maxLineCycles * maxFrameLines + marginCycles) * clkPeriod);
		stopWithFailure("Timeout: the simulation did not finish in the expected time");
	end

	// Returns at the negedge of the acknowledge cycle with the strobe still up
	task automatic busStart(input logic we, input logic [11:0] adr, input logic [3:0] sel,
			input logic [31:0] dat, output logic [31:0] rdat);
		int waited;
		@(posedge vga_clk);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe <= we;
		wbAdr <= adr;
		wbSel <= sel;
		wbDatW <= dat;
		waited = 0;
		@(negedge vga_clk);
		while (!wbAck) begin
			waited++;
			if (waited > 4) begin
				stopWithFailure("Wishbone access was never acknowledged");
			end
			@(negedge vga_clk);
		end
		rdat = wbDatR;
	endtask

	task automatic busEnd();
		@(posedge vga_clk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe <= 1'b0;
		@(negedge vga_clk);
		checkEq("ack length", 0, wbAck);
	endtask

	task automatic busWrite(input logic [11:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [31:0] unused;
		busStart(1'b1, adr, sel, dat, unused);
		busEnd();
	endtask

	task automatic busRead(input logic [11:0] adr, output logic [31:0] rdat);
		busStart(1'b0, adr, 4'hF, 32'h0, rdat);
		busEnd();
	endtask

	task automatic checkResetValues();
		logic [31:0] rd;
		for (int i = 0; i < 9; i++) begin
			busRead(regOffset[i], rd);
			checkEq("reset value", regDefault[i], rd);
		end
		// Disabled timing keeps both visible flags up and the syncs inactive
		busRead(statusAdr, rd);
		checkEq("reset status", 32'h18, rd);
		for (int i = 0; i < 4; i++) begin
			busRead(unmappedOffset[i], rd);
			checkEq("unmapped read", 32'hFFFF_FFFF, rd);
		end
	endtask

	task automatic checkRegisterWrites();
		logic [31:0] shadow [9];
		logic [31:0] data, selMask, expected, rd;
		logic [3:0] sel;
		int idx;
		for (int i = 0; i < 9; i++) begin
			shadow[i] = regDefault[i];
		end
		repeat (30) begin
			idx = nextRandom() % 9;
			data = nextRandom();
			sel = 4'(nextRandom());
			selMask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
			expected = ((shadow[idx] & ~selMask) | (data & selMask)) & regMask[idx];
			busWrite(regOffset[idx], sel, data);
			busRead(regOffset[idx], rd);
			checkEq("register readback", expected, rd);
			shadow[idx] = expected;
		end
	endtask

	task automatic checkDisabledOutput();
		logic [31:0] rd;
		busWrite(configAdr, 4'hF, 32'h0);
		repeat (100) begin
			@(negedge vga_clk);
			checkEq("disabled syncs", 2'b11, {vgaVsync, vgaHsync});
			checkEq("disabled colour", 0, {vgaB, vgaG, vgaR});
			checkEq("disabled fetch", 0, fetchData);
		end
		busRead(statusAdr, rd);
		checkEq("disabled status", 32'h18, rd);
	endtask

	task automatic resetModel();
		mHc = 0;
		mVc = 0;
		mHVis = 1'b1;
		mVVis = 1'b1;
		mHs = 1'b1;
		mVs = 1'b1;
		mHSt = 0;
		mVSt = 0;
		mSub = 0;
		mCol = 0;
		mRow = 0;
		lastFetchValid = 1'b0;
		expQ.delete();
		// Pins stay idle for the first two enabled cycles
		expQ.push_back(8'hC0);
		expQ.push_back(8'hC0);
	endtask

	// Called at the negedge of each enabled cycle with the model holding that cycle's state
	task automatic checkCycle();
		logic [7:0] expected;
		logic [31:0] word;
		logic [5:0] pix;
		logic [12:0] nextAddr;
		logic onScreen, lineEnd, subWrap;
		int row, col, sub;
		int nHSt, nVSt, nSub, nCol, nRow;

		expected = expQ.pop_front();
		checkEq("sync outputs", expected[7:6], {vgaVsync, vgaHsync});
		checkEq("pixel colour", expected[5:0], {vgaB, vgaG, vgaR});

		// Stretched row and column pick the word and the stretch phase picks the pixel
		onScreen = mHVis && mVVis;
		pix = '0;
		if (onScreen) begin
			row = mVc / (tVps + 1);
			col = mHc / (5 * (tHps + 1));
			sub = (mHc / (tHps + 1)) % 5;
			word = frameMem[{row[6:0], col[3:0], 2'b00}];
			pix = word[sub * 6 +: 6];
		end
		expQ.push_back({mVs, mHs, pix});

		lineEnd = mHc == tHWhole;
		subWrap = mSub == 4;
		nHSt = 0;
		nSub = 0;
		nCol = 0;
		nVSt = 0;
		nRow = 0;
		if (mVVis) begin
			nVSt = mVSt;
			nRow = mRow;
			if (mHVis) begin
				nHSt = (mHSt == tHps) ? 0 : mHSt + 1;
				nSub = (mHSt != tHps) ? mSub : (subWrap ? 0 : mSub + 1);
				nCol = (mHSt == tHps && subWrap) ? mCol + 1 : mCol;
			end
			if (lineEnd) begin
				nVSt = (mVSt == tVps) ? 0 : mVSt + 1;
				nRow = (mVSt == tVps) ? mRow + 1 : mRow;
			end
		end

		// A new word is requested whenever the row or column moves
		nextAddr = {nRow[6:0], nCol[3:0], 2'b00};
		if (nRow != mRow || nCol != mCol) begin
			checkEq("fetch strobe", 1, fetchData);
		end
		if (fetchData) begin
			checkEq("fetch address", nextAddr, pixelAddress);
			if (onScreen && lastFetchValid) begin
				checkEq("repeated fetch", 1, pixelAddress != lastFetchAddr);
			end
			lastFetchAddr = pixelAddress;
			lastFetchValid = 1'b1;
		end
		if (!onScreen) begin
			lastFetchValid = 1'b0;
		end
		mHSt = nHSt;
		mVSt = nVSt;
		mSub = nSub;
		mCol = nCol;
		mRow = nRow;

		if (mHc == tHVis) begin
			mHVis = 1'b0;
		end else if (lineEnd) begin
			mHVis = 1'b1;
		end
		if (mHc == tHFp) begin
			mHs = 1'b0;
		end else if (mHc == tHSync) begin
			mHs = 1'b1;
		end
		if (lineEnd) begin
			if (mVc == tVVis) begin
				mVVis = 1'b0;
			end else if (mVc == tVWhole) begin
				mVVis = 1'b1;
			end
			if (mVc == tVFp) begin
				mVs = 1'b0;
			end else if (mVc == tVSync) begin
				mVs = 1'b1;
			end
			mVc = (mVc == tVWhole) ? 0 : mVc + 1;
		end
		mHc = lineEnd ? 0 : mHc + 1;
	endtask

	task automatic runRandomTiming();
		logic [31:0] rd;
		int cycles;
		// Lines of 20 to 40 cycles and frames of 12 to 20 lines
		tHWhole = 19 + nextRandom() % 21;
		tHSync = tHWhole - 1 - nextRandom() % 3;
		tHFp = tHSync - 1 - nextRandom() % 3;
		tHVis = tHFp - 1 - nextRandom() % 4;
		tVWhole = 11 + nextRandom() % 9;
		tVSync = tVWhole - 1 - nextRandom() % 2;
		tVFp = tVSync - 1 - nextRandom() % 2;
		tVVis = tVFp - 1 - nextRandom() % 2;
		tHps = nextRandom() % 4;
		tVps = nextRandom() % 4;
		busWrite(regOffset[1], 4'hF, tHVis);
		busWrite(regOffset[2], 4'hF, tHFp);
		busWrite(regOffset[3], 4'hF, tHSync);
		busWrite(regOffset[4], 4'hF, tHWhole);
		busWrite(regOffset[5], 4'hF, tVVis);
		busWrite(regOffset[6], 4'hF, tVFp);
		busWrite(regOffset[7], 4'hF, tVSync);
		busWrite(regOffset[8], 4'hF, tVWhole);
		resetModel();
		// The acknowledge cycle of the enabling write is cycle 0
		busStart(1'b1, configAdr, 4'hF, 32'h400 | (tVps << 4) | tHps, rd);
		cycles = 2 * (tHWhole + 1) * (tVWhole + 1);
		fork
			busEnd();
			for (int n = 0; n < cycles; n++) begin
				checkCycle();
				@(negedge vga_clk);
			end
		join
		// Status shows the enable bit while the timing runs
		busRead(statusAdr, rd);
		checkEq("enabled status", 1, rd[0]);
		busWrite(configAdr, 4'hF, 32'h0);
	endtask

	initial begin
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbSel = '0;
		wbDatW = '0;
		pixelData = '0;
		for (int i = 0; i < 8192; i++) begin
			frameMem[i] = nextRandom();
		end
		repeat (16) @(posedge vga_clk);
		rstN <= 1'b1;
		checkResetValues();
		checkRegisterWrites();
		checkDisabledOutput();
		for (int r = 0; r < numRuns; r++) begin
			runRandomTiming();
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/vgaPkg.sv
hw/vgaRegisterBank.sv
hw/vgaTimingGenerator.sv
hw/vgaPixelFetch.sv
hw/vgaController.sv
test/vgaControllerTb.sv

// ==== Bender.yml ====
package:
  name: vga_controller

sources:
  - hw/vgaPkg.sv
  - hw/vgaRegisterBank.sv
  - hw/vgaTimingGenerator.sv
  - hw/vgaPixelFetch.sv
  - hw/vgaController.sv
  - target: test
    files:
      - test/vgaControllerTb.sv
